/* source/matrix_pkg.sv */
package matrix_pkg;

    // ==============================
    // Format constants
    // ==============================
    localparam int DATA_WIDTH     = 8;
    localparam int INSTR_WIDTH    = 32;
    localparam int ROW_BITS       = 3;
    localparam int RAM_ADDR_WIDTH = 10;
    localparam int TOP_OFFSET     = 64;

    // Bit position inside the flags field
    localparam int FLAG_IMM       = 0;

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic [ROW_BITS-1:0]          row_t;
    typedef logic [RAM_ADDR_WIDTH-1:0]    ram_addr_t;

    // ==============================
    // Instruction word
    // ==============================
    typedef struct packed {
        row_t      row;
        ram_addr_t addr;
    } ram_view_t;

    typedef struct packed {
        row_t       row;
        logic [1:0] unused;
        data_t      imm;
    } imm_view_t;

    // Low 13 bits, read as RAM address or immediate depending on flags
    typedef union packed {
        ram_view_t ram;
        imm_view_t imm;
    } operand_u;

    typedef struct packed {
        logic       load_left;
        logic       load_top;
        logic       swap_left;
        logic       swap_top;
        logic       shift_right;
        logic       shift_down;
        logic       load_acc;
        logic [6:0] reserved;
        logic [4:0] flags;
        operand_u   operand;
    } instruction_t;

    // ==============================
    // Datapath controls
    // ==============================
    typedef struct packed {
        logic  load_en;
        logic  swap;
        row_t  row;
        data_t data;
    } buffer_ctrl_t;

    typedef struct packed {
        logic shift_right;
        logic shift_down;
        logic acc_en;
    } grid_ctrl_t;

    typedef enum logic [1:0] {
        IDLE,
        PRE_FETCH,
        EXECUTE,
        LOAD_COMMIT
    } seq_state_t;

endpackage

/* source/operand_ram.sv */
`timescale 1ns/100ps

module operand_ram (
    input  logic                  clk,
    input  logic                  we,
    input  matrix_pkg::ram_addr_t wr_addr,
    input  matrix_pkg::data_t     wr_data,
    input  matrix_pkg::ram_addr_t a_addr,
    input  matrix_pkg::ram_addr_t b_addr,
    output matrix_pkg::data_t     a_data,
    output matrix_pkg::data_t     b_data
);

    matrix_pkg::data_t mem [2 ** matrix_pkg::RAM_ADDR_WIDTH];

    // External write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered reads see the old word on a same-address write
    always_ff @(posedge clk) begin
        a_data <= mem[a_addr];
        b_data <= mem[b_addr];
    end

endmodule

/* source/operand_double_buffer.sv */
`timescale 1ns/100ps

module operand_double_buffer #(
    parameter int MATRIX_SIZE = 4
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  matrix_pkg::buffer_ctrl_t                 ctrl,
    output matrix_pkg::data_t [MATRIX_SIZE-1:0]      vector
);

    // Two banks, one feeding the grid and one taking loads
    matrix_pkg::data_t [1:0][MATRIX_SIZE-1:0] bank;
    logic                                     active;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank   <= '0;
            active <= 1'b0;
        end else begin
            if (ctrl.swap) begin
                active <= ~active;
            end
            // Uses the pre-edge select, so a load with a swap lands in the old loading half
            if (ctrl.load_en) begin
                bank[~active][ctrl.row] <= ctrl.data;
            end
        end
    end

    assign vector = bank[active];

    a_row_range: assert property (@(posedge clk) disable iff (rst)
        ctrl.load_en |-> (ctrl.row < MATRIX_SIZE))
        else $error("buffer load row %0d beyond MATRIX_SIZE", ctrl.row);

endmodule

/* source/mac_cell.sv */
`timescale 1ns/100ps

module mac_cell #(
    parameter int ACC_WIDTH = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    input  matrix_pkg::grid_ctrl_t      ctrl,
    input  matrix_pkg::data_t           in_left,
    input  matrix_pkg::data_t           in_top,
    output matrix_pkg::data_t           out_right,
    output matrix_pkg::data_t           out_bottom,
    output logic signed [ACC_WIDTH-1:0] acc
);

    logic signed [2*matrix_pkg::DATA_WIDTH-1:0] product;

    // Full-width signed product, sign extended into the sum
    assign product = in_left * in_top;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc        <= '0;
            out_right  <= '0;
            out_bottom <= '0;
        end else begin
            if (ctrl.acc_en) begin
                acc <= acc + product;
            end
            if (ctrl.shift_right) begin
                out_right <= in_left;
            end
            if (ctrl.shift_down) begin
                out_bottom <= in_top;
            end
        end
    end

endmodule

/* source/systolic_grid.sv */
`timescale 1ns/100ps

module systolic_grid #(
    parameter int  MATRIX_SIZE    = 4,
    parameter int  ACC_WIDTH      = 32,
    localparam int ACC_ADDR_WIDTH = $clog2(MATRIX_SIZE * MATRIX_SIZE)
) (
    input  logic                                clk,
    input  logic                                rst,
    input  matrix_pkg::grid_ctrl_t              ctrl,
    input  matrix_pkg::data_t [MATRIX_SIZE-1:0] left_vec,
    input  matrix_pkg::data_t [MATRIX_SIZE-1:0] top_vec,
    input  logic [ACC_ADDR_WIDTH-1:0]           acc_addr,
    output logic signed [ACC_WIDTH-1:0]         acc_out
);

    matrix_pkg::data_t           right_q [MATRIX_SIZE][MATRIX_SIZE];
    matrix_pkg::data_t           down_q  [MATRIX_SIZE][MATRIX_SIZE];
    logic signed [ACC_WIDTH-1:0] acc_q   [MATRIX_SIZE*MATRIX_SIZE];

    // ==============================
    // Cell array
    // ==============================
    for (genvar r = 0; r < MATRIX_SIZE; r++) begin : g_row
        for (genvar c = 0; c < MATRIX_SIZE; c++) begin : g_col
            matrix_pkg::data_t cell_left;
            matrix_pkg::data_t cell_top;

            // Edge cells feed from the buffers
            if (c == 0) begin : g_left_edge
                assign cell_left = left_vec[r];
            end else begin : g_left_inner
                assign cell_left = right_q[r][c-1];
            end

            if (r == 0) begin : g_top_edge
                assign cell_top = top_vec[c];
            end else begin : g_top_inner
                assign cell_top = down_q[r-1][c];
            end

            mac_cell #(
                .ACC_WIDTH(ACC_WIDTH)
            ) i_mac_cell (
                .clk       (clk),
                .rst       (rst),
                .ctrl      (ctrl),
                .in_left   (cell_left),
                .in_top    (cell_top),
                .out_right (right_q[r][c]),
                .out_bottom(down_q[r][c]),
                .acc       (acc_q[r*MATRIX_SIZE+c])
            );
        end
    end

    // Row-major readout
    assign acc_out = acc_q[acc_addr];

    a_acc_addr_range: assert property (@(posedge clk) disable iff (rst)
        acc_addr < MATRIX_SIZE * MATRIX_SIZE)
        else $error("accumulator address %0d out of range", acc_addr);

endmodule

/* source/instr_sequencer.sv */
`timescale 1ns/100ps

module instr_sequencer #(
    parameter int  MATRIX_SIZE = 4,
    parameter int  PROG_DEPTH  = 256,
    localparam int PC_WIDTH    = $clog2(PROG_DEPTH)
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     prog_we,
    input  logic [PC_WIDTH-1:0]      prog_addr,
    input  matrix_pkg::instruction_t prog_data,
    input  logic                     step,
    output logic                     ready,
    output matrix_pkg::ram_addr_t    left_rd_addr,
    output matrix_pkg::ram_addr_t    top_rd_addr,
    input  matrix_pkg::data_t        left_rd_data,
    input  matrix_pkg::data_t        top_rd_data,
    output matrix_pkg::buffer_ctrl_t left_ctrl,
    output matrix_pkg::buffer_ctrl_t top_ctrl,
    output matrix_pkg::grid_ctrl_t   grid_ctrl,
    output logic [PC_WIDTH-1:0]      pc_out,
    output matrix_pkg::seq_state_t   state_out
);

    // Row field must be able to reach every grid row
    if (MATRIX_SIZE > 2 ** matrix_pkg::ROW_BITS) begin : g_size_check
        $error("MATRIX_SIZE does not fit the instruction row field");
    end

    logic [matrix_pkg::INSTR_WIDTH-1:0] prog_mem [PROG_DEPTH];
    logic [matrix_pkg::INSTR_WIDTH-1:0] fetch_word;

    logic [PC_WIDTH-1:0]      pc;
    matrix_pkg::seq_state_t   state;
    matrix_pkg::instruction_t next_instr;
    matrix_pkg::instruction_t curr_instr;
    logic                     hold;
    logic                     accept;
    logic                     imm;
    logic                     commit_left;
    logic                     commit_top;
    matrix_pkg::row_t         commit_row;
    logic                     ctrl_active;

    // ==============================
    // Program memory
    // ==============================
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
        fetch_word <= prog_mem[pc];
    end

    // Hold covers the fetch latency, and the RAM latency in LOAD_COMMIT
    assign ready  = ~hold;
    assign accept = step & ready;
    assign imm    = curr_instr.flags[matrix_pkg::FLAG_IMM];

    // RAM is read at the accepting edge, straight from the current word
    assign left_rd_addr = curr_instr.operand.ram.addr;
    assign top_rd_addr  = (curr_instr.load_left && curr_instr.load_top)
                        ? curr_instr.operand.ram.addr
                          + matrix_pkg::ram_addr_t'(matrix_pkg::TOP_OFFSET)
                        : curr_instr.operand.ram.addr;

    // ==============================
    // Fetch / execute FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= matrix_pkg::IDLE;
            pc          <= '0;
            hold        <= 1'b0;
            next_instr  <= '0;
            curr_instr  <= '0;
            commit_left <= 1'b0;
            commit_top  <= 1'b0;
            commit_row  <= '0;
            left_ctrl   <= '0;
            top_ctrl    <= '0;
            grid_ctrl   <= '0;
        end else begin
            hold      <= accept || (state == matrix_pkg::LOAD_COMMIT);
            left_ctrl <= '0;
            top_ctrl  <= '0;
            grid_ctrl <= '0;

            if (accept) begin
                pc         <= pc + 1'b1;
                next_instr <= matrix_pkg::instruction_t'(fetch_word);
            end

            case (state)
                matrix_pkg::IDLE: begin
                    if (accept) begin
                        state <= matrix_pkg::PRE_FETCH;
                    end
                end
                matrix_pkg::PRE_FETCH: begin
                    if (accept) begin
                        curr_instr <= next_instr;
                        state      <= matrix_pkg::EXECUTE;
                    end
                end
                matrix_pkg::EXECUTE: begin
                    if (accept) begin
                        curr_instr            <= next_instr;
                        left_ctrl.swap        <= curr_instr.swap_left;
                        top_ctrl.swap         <= curr_instr.swap_top;
                        grid_ctrl.shift_right <= curr_instr.shift_right;
                        grid_ctrl.shift_down  <= curr_instr.shift_down;
                        grid_ctrl.acc_en      <= curr_instr.load_acc;

                        if (imm) begin
                            left_ctrl.load_en <= curr_instr.load_left;
                            left_ctrl.row     <= curr_instr.operand.imm.row;
                            left_ctrl.data    <= curr_instr.operand.imm.imm;
                            top_ctrl.load_en  <= curr_instr.load_top;
                            top_ctrl.row      <= curr_instr.operand.imm.row;
                            top_ctrl.data     <= curr_instr.operand.imm.imm;
                        end else if (curr_instr.load_left || curr_instr.load_top) begin
                            // RAM data arrives next cycle
                            commit_left <= curr_instr.load_left;
                            commit_top  <= curr_instr.load_top;
                            commit_row  <= curr_instr.operand.ram.row;
                            state       <= matrix_pkg::LOAD_COMMIT;
                        end
                    end
                end
                matrix_pkg::LOAD_COMMIT: begin
                    left_ctrl.load_en <= commit_left;
                    left_ctrl.row     <= commit_row;
                    left_ctrl.data    <= left_rd_data;
                    top_ctrl.load_en  <= commit_top;
                    top_ctrl.row      <= commit_row;
                    top_ctrl.data     <= top_rd_data;
                    state             <= matrix_pkg::EXECUTE;
                end
                default: begin
                    state <= matrix_pkg::IDLE;
                end
            endcase
        end
    end

    assign pc_out    = pc;
    assign state_out = state;

    // ==============================
    // Checks
    // ==============================
    assign ctrl_active = left_ctrl.load_en | left_ctrl.swap | top_ctrl.load_en
                       | top_ctrl.swap | (|grid_ctrl);

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {matrix_pkg::IDLE, matrix_pkg::PRE_FETCH,
                      matrix_pkg::EXECUTE, matrix_pkg::LOAD_COMMIT})
        else $error("sequencer state left the legal encodings");

    // Every pulse traces back to an accepted step or a RAM commit
    a_ctrl_cause: assert property (@(posedge clk) disable iff (rst)
        ctrl_active |-> $past(accept || state == matrix_pkg::LOAD_COMMIT))
        else $error("control pulse without accepted step or load commit");

endmodule

/* source/matrix_engine_top.sv */
`timescale 1ns/100ps

module matrix_engine_top #(
    parameter int  MATRIX_SIZE    = 4,
    parameter int  ACC_WIDTH      = 32,
    parameter int  PROG_DEPTH     = 256,
    localparam int PC_WIDTH       = $clog2(PROG_DEPTH),
    localparam int ACC_ADDR_WIDTH = $clog2(MATRIX_SIZE * MATRIX_SIZE)
) (
    input  logic                     clk,
    input  logic                     rst,
    // Program write
    input  logic                     prog_we,
    input  logic [PC_WIDTH-1:0]      prog_addr,
    input  matrix_pkg::instruction_t prog_data,
    // Operand write
    input  logic                     ram_we,
    input  matrix_pkg::ram_addr_t    ram_addr,
    input  matrix_pkg::data_t        ram_data,
    // Stepping
    input  logic                     step,
    output logic                     ready,
    // Readout
    input  logic [ACC_ADDR_WIDTH-1:0] acc_addr,
    output logic signed [ACC_WIDTH-1:0] acc_out,
    // Debug
    output logic [PC_WIDTH-1:0]      pc_out,
    output matrix_pkg::seq_state_t   state_out
);

    matrix_pkg::ram_addr_t                left_rd_addr;
    matrix_pkg::ram_addr_t                top_rd_addr;
    matrix_pkg::data_t                    left_rd_data;
    matrix_pkg::data_t                    top_rd_data;
    matrix_pkg::buffer_ctrl_t             left_ctrl;
    matrix_pkg::buffer_ctrl_t             top_ctrl;
    matrix_pkg::grid_ctrl_t               grid_ctrl;
    matrix_pkg::data_t [MATRIX_SIZE-1:0]  left_vec;
    matrix_pkg::data_t [MATRIX_SIZE-1:0]  top_vec;

    // ==============================
    // Producer side
    // ==============================
    instr_sequencer #(
        .MATRIX_SIZE(MATRIX_SIZE),
        .PROG_DEPTH (PROG_DEPTH)
    ) i_instr_sequencer (
        .clk         (clk),
        .rst         (rst),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .step        (step),
        .ready       (ready),
        .left_rd_addr(left_rd_addr),
        .top_rd_addr (top_rd_addr),
        .left_rd_data(left_rd_data),
        .top_rd_data (top_rd_data),
        .left_ctrl   (left_ctrl),
        .top_ctrl    (top_ctrl),
        .grid_ctrl   (grid_ctrl),
        .pc_out      (pc_out),
        .state_out   (state_out)
    );

    operand_ram i_operand_ram (
        .clk    (clk),
        .we     (ram_we),
        .wr_addr(ram_addr),
        .wr_data(ram_data),
        .a_addr (left_rd_addr),
        .b_addr (top_rd_addr),
        .a_data (left_rd_data),
        .b_data (top_rd_data)
    );

    // ==============================
    // Operand buffers and grid
    // ==============================
    operand_double_buffer #(
        .MATRIX_SIZE(MATRIX_SIZE)
    ) i_left_buffer (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (left_ctrl),
        .vector(left_vec)
    );

    operand_double_buffer #(
        .MATRIX_SIZE(MATRIX_SIZE)
    ) i_top_buffer (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (top_ctrl),
        .vector(top_vec)
    );

    systolic_grid #(
        .MATRIX_SIZE(MATRIX_SIZE),
        .ACC_WIDTH  (ACC_WIDTH)
    ) i_systolic_grid (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (grid_ctrl),
        .left_vec(left_vec),
        .top_vec (top_vec),
        .acc_addr(acc_addr),
        .acc_out (acc_out)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Reset drops just after an edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* tests/matrix_engine_tb.sv */
`timescale 1ns/100ps

module matrix_engine_tb;

    localparam int MATRIX_SIZE    = 4;
    localparam int ACC_WIDTH      = 32;
    localparam int PROG_DEPTH     = 256;
    localparam int PC_WIDTH       = $clog2(PROG_DEPTH);
    localparam int ACC_ADDR_WIDTH = $clog2(MATRIX_SIZE * MATRIX_SIZE);
    localparam int RAM_WORDS      = 2 ** matrix_pkg::RAM_ADDR_WIDTH;
    localparam int CLK_PERIOD     = 20;

    // Each phase steps through its words plus two padding words
    localparam int TOTAL_STEPS     = (10 + 2) + (8 + 2) + (16 + 2) + (10 + 2) + (2 + 2);
    // At most 4 cycles per step
    // Program writes and readout fit in the margin
    localparam int WATCHDOG_CYCLES = TOTAL_STEPS * 4 + 400;

    logic                        clk;
    logic                        rst;
    logic                        prog_we;
    logic [PC_WIDTH-1:0]         prog_addr;
    matrix_pkg::instruction_t    prog_data;
    logic                        ram_we;
    matrix_pkg::ram_addr_t       ram_addr;
    matrix_pkg::data_t           ram_data;
    logic                        step;
    logic                        ready;
    logic [ACC_ADDR_WIDTH-1:0]   acc_addr;
    logic signed [ACC_WIDTH-1:0] acc_out;
    logic [PC_WIDTH-1:0]         pc_out;
    matrix_pkg::seq_state_t      state_out;

    int errors = 0;
    int checks = 0;
    logic [31:0] lfsr = 32'h6ed4_760e;

    // Program shadow and words waiting for the next phase
    matrix_pkg::instruction_t shadow [PROG_DEPTH];
    matrix_pkg::instruction_t pending [$];
    int wr_ptr = 0;
    // Accepted steps so far, which is the pc the DUT should show
    int exp_pc = 0;

    // ==============================
    // Reference model state
    // ==============================
    matrix_pkg::data_t left_m  [2][MATRIX_SIZE] = '{default: '0};
    matrix_pkg::data_t top_m   [2][MATRIX_SIZE] = '{default: '0};
    matrix_pkg::data_t right_m [MATRIX_SIZE][MATRIX_SIZE] = '{default: '0};
    matrix_pkg::data_t down_m  [MATRIX_SIZE][MATRIX_SIZE] = '{default: '0};
    int                acc_m   [MATRIX_SIZE][MATRIX_SIZE] = '{default: 0};
    matrix_pkg::data_t ram_m   [RAM_WORDS];
    int left_act = 0;
    int top_act  = 0;

    tb_clock #(
        .PERIOD      (CLK_PERIOD),
        .RESET_CYCLES(2)
    ) i_tb_clock (
        .clk(clk),
        .rst(rst)
    );

    matrix_engine_top #(
        .MATRIX_SIZE(MATRIX_SIZE),
        .ACC_WIDTH  (ACC_WIDTH),
        .PROG_DEPTH (PROG_DEPTH)
    ) i_matrix_engine_top (
        .clk      (clk),
        .rst      (rst),
        .prog_we  (prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .ram_we   (ram_we),
        .ram_addr (ram_addr),
        .ram_data (ram_data),
        .step     (step),
        .ready    (ready),
        .acc_addr (acc_addr),
        .acc_out  (acc_out),
        .pc_out   (pc_out),
        .state_out(state_out)
    );

    a_busy_after_step: assert property (@(posedge clk) disable iff (rst)
        (step && ready) |=> !ready)
        else begin
            errors++;
            $display("ERR %0t: ready still high after an accepted step", $time);
        end

    a_pc_hold: assert property (@(posedge clk) disable iff (rst)
        !(step && ready) |=> $stable(pc_out))
        else begin
            errors++;
            $display("ERR %0t: pc moved without an accepted step", $time);
        end

    // Fibonacci LFSR with taps 32 22 2 1 and one shift per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] value;
        logic       fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[6:0], fb};
        end
        return value;
    endfunction

    function automatic matrix_pkg::instruction_t imm_load(input logic left, input logic top,
                                                          input int row, input logic [7:0] value);
        matrix_pkg::instruction_t w;
        w                                 = '0;
        w.load_left                       = left;
        w.load_top                        = top;
        w.flags[matrix_pkg::FLAG_IMM]     = 1'b1;
        w.operand.imm.row                 = matrix_pkg::row_t'(row);
        w.operand.imm.imm                 = value;
        return w;
    endfunction

    function automatic matrix_pkg::instruction_t ram_load(input logic left, input logic top,
                                                          input int row, input int addr);
        matrix_pkg::instruction_t w;
        w                  = '0;
        w.load_left        = left;
        w.load_top         = top;
        w.operand.ram.row  = matrix_pkg::row_t'(row);
        w.operand.ram.addr = matrix_pkg::ram_addr_t'(addr);
        return w;
    endfunction

    // Swap acts on both buffers
    function automatic matrix_pkg::instruction_t ctrl_word(input logic swap, input logic right,
                                                           input logic down, input logic acc);
        matrix_pkg::instruction_t w;
        w             = '0;
        w.swap_left   = swap;
        w.swap_top    = swap;
        w.shift_right = right;
        w.shift_down  = down;
        w.load_acc    = acc;
        return w;
    endfunction

    // Grid sees the pre-edge vectors
    // RAM data lands after any swap
    task automatic model_exec(input matrix_pkg::instruction_t w);
        matrix_pkg::data_t in_l [MATRIX_SIZE][MATRIX_SIZE];
        matrix_pkg::data_t in_t [MATRIX_SIZE][MATRIX_SIZE];
        int                addr;
        int                row;
        for (int r = 0; r < MATRIX_SIZE; r++) begin
            for (int c = 0; c < MATRIX_SIZE; c++) begin
                in_l[r][c] = (c == 0) ? left_m[left_act][r] : right_m[r][c-1];
                in_t[r][c] = (r == 0) ? top_m[top_act][c] : down_m[r-1][c];
            end
        end
        for (int r = 0; r < MATRIX_SIZE; r++) begin
            for (int c = 0; c < MATRIX_SIZE; c++) begin
                if (w.load_acc) acc_m[r][c] += int'(in_l[r][c]) * int'(in_t[r][c]);
                if (w.shift_right) right_m[r][c] = in_l[r][c];
                if (w.shift_down) down_m[r][c] = in_t[r][c];
            end
        end
        if (w.flags[matrix_pkg::FLAG_IMM]) begin
            row = int'(w.operand.imm.row);
            if (w.load_left) left_m[1-left_act][row] = w.operand.imm.imm;
            if (w.load_top) top_m[1-top_act][row] = w.operand.imm.imm;
        end
        if (w.swap_left) left_act = 1 - left_act;
        if (w.swap_top) top_act = 1 - top_act;
        if (!w.flags[matrix_pkg::FLAG_IMM]) begin
            row  = int'(w.operand.ram.row);
            addr = int'(w.operand.ram.addr);
            if (w.load_left) left_m[1-left_act][row] = ram_m[addr];
            if (w.load_top && w.load_left) begin
                top_m[1-top_act][row] = ram_m[(addr + matrix_pkg::TOP_OFFSET) % RAM_WORDS];
            end else if (w.load_top) begin
                top_m[1-top_act][row] = ram_m[addr];
            end
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready) begin
            if (cycles == 10) begin
                errors++;
                $display("Ready never came back, stepping gave up at %0t", $time);
                return;
            end
            cycles++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic ram_write(input int addr, input logic [7:0] value);
        ram_we   = 1'b1;
        ram_addr = matrix_pkg::ram_addr_t'(addr);
        ram_data = value;
        ram_m[addr] = value;
        @(posedge clk);
        #1;
        ram_we = 1'b0;
    endtask

    // Step number k executes the word at pc - 2 once two prefetches are done
    task automatic step_once();
        int                       pc_before;
        int                       expect_low;
        int                       low_cycles;
        logic [7:0]               hold_bit;
        matrix_pkg::instruction_t w;
        wait_ready();
        hold_bit   = rand_bits(1);
        pc_before  = exp_pc;
        w          = (pc_before >= 2) ? shadow[pc_before-2] : '0;
        expect_low = (!w.flags[matrix_pkg::FLAG_IMM] && (w.load_left || w.load_top)) ? 2 : 1;
        step = 1'b1;
        @(posedge clk);
        #1;
        // Step left high over busy cycles must not count again
        if (!hold_bit[0]) step = 1'b0;
        low_cycles = 0;
        while (!ready && low_cycles < 4) begin
            low_cycles++;
            @(posedge clk);
            #1;
        end
        step   = 1'b0;
        exp_pc = pc_before + 1;
        checks += 2;
        assert (low_cycles == expect_low) else begin
            errors++;
            $display("ERR %0t: ready low %0d cycles, expected %0d", $time, low_cycles, expect_low);
        end
        assert (int'(pc_out) == exp_pc % PROG_DEPTH) else begin
            errors++;
            $display("ERR %0t: pc %0d after step from %0d", $time, pc_out, pc_before);
        end
        if (pc_before >= 2) model_exec(w);
    endtask

    // Pads with two empty words so the phase drains the fetch pipeline
    task automatic run_phase();
        int n;
        n = pending.size();
        pending.push_back('0);
        pending.push_back('0);
        prog_we = 1'b1;
        foreach (pending[i]) begin
            prog_addr      = PC_WIDTH'(wr_ptr);
            prog_data      = pending[i];
            shadow[wr_ptr] = pending[i];
            wr_ptr++;
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        pending.delete();
        repeat (n + 2) step_once();
    endtask

    task automatic check_accs(input string tag);
        int r;
        int c;
        for (int i = 0; i < MATRIX_SIZE * MATRIX_SIZE; i++) begin
            r        = i / MATRIX_SIZE;
            c        = i % MATRIX_SIZE;
            acc_addr = ACC_ADDR_WIDTH'(i);
            #1;
            checks++;
            assert (acc_out == acc_m[r][c]) else begin
                errors++;
                $display("ERR %0t: %s acc(%0d,%0d) is %0d, expected %0d",
                         $time, tag, r, c, acc_out, acc_m[r][c]);
            end
            @(posedge clk);
            #1;
        end
    endtask

    // ==============================
    // Test phases
    // ==============================
    task automatic immediate_products();
        matrix_pkg::data_t left_vals [MATRIX_SIZE];
        matrix_pkg::data_t top_vals  [MATRIX_SIZE];
        for (int r = 0; r < MATRIX_SIZE; r++) begin
            left_vals[r] = rand_bits(8);
            top_vals[r]  = rand_bits(8);
            pending.push_back(imm_load(1'b1, 1'b0, r, left_vals[r]));
            pending.push_back(imm_load(1'b0, 1'b1, r, top_vals[r]));
        end
        pending.push_back(ctrl_word(1'b1, 1'b0, 1'b0, 1'b0));
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        run_phase();
        // Corner cell takes both operands straight from the buffers
        acc_addr = '0;
        #1;
        checks++;
        assert (acc_out == int'(left_vals[0]) * int'(top_vals[0])) else begin
            errors++;
            $display("ERR %0t: acc(0,0) is %0d, expected %0d", $time, acc_out,
                     int'(left_vals[0]) * int'(top_vals[0]));
        end
        check_accs("immediate");
    endtask

    task automatic shifted_products();
        pending.push_back(ctrl_word(1'b0, 1'b1, 1'b1, 1'b0));
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        pending.push_back(ctrl_word(1'b0, 1'b1, 1'b0, 1'b0));
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b1, 1'b1));
        pending.push_back(ctrl_word(1'b0, 1'b1, 1'b1, 1'b1));
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b1, 1'b0));
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        pending.push_back(ctrl_word(1'b0, 1'b1, 1'b0, 1'b1));
        run_phase();
        check_accs("shifts");
    endtask

    task automatic ram_operand_products();
        for (int r = 0; r < MATRIX_SIZE; r++) begin
            ram_write(16 + r, rand_bits(8));
            ram_write(16 + r + matrix_pkg::TOP_OFFSET, rand_bits(8));
            ram_write(200 + r, rand_bits(8));
            ram_write(300 + r, rand_bits(8));
            // Decoys a single top load must not reach
            ram_write(300 + r + matrix_pkg::TOP_OFFSET, rand_bits(8));
        end
        for (int r = 0; r < MATRIX_SIZE; r++) pending.push_back(ram_load(1'b1, 1'b1, r, 16 + r));
        pending.push_back(ctrl_word(1'b1, 1'b0, 1'b0, 1'b0));
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        for (int r = 0; r < MATRIX_SIZE; r++) pending.push_back(ram_load(1'b1, 1'b0, r, 200 + r));
        for (int r = 0; r < MATRIX_SIZE; r++) pending.push_back(ram_load(1'b0, 1'b1, r, 300 + r));
        pending.push_back(ctrl_word(1'b1, 1'b0, 1'b0, 1'b1));
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        run_phase();
        check_accs("ram");
    endtask

    // Loads fill the idle half while the active half keeps feeding the grid
    task automatic idle_half_reload();
        for (int r = 0; r < MATRIX_SIZE; r++) begin
            pending.push_back(imm_load(1'b1, 1'b0, r, rand_bits(8)));
            pending.push_back(imm_load(1'b0, 1'b1, r, rand_bits(8)));
            if (r == 1) pending.push_back(ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        end
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        run_phase();
        check_accs("reload");
        pending.push_back(ctrl_word(1'b1, 1'b0, 1'b0, 1'b1));
        pending.push_back(ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        run_phase();
        check_accs("swap");
    endtask

    initial begin
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        ram_we    = 1'b0;
        ram_addr  = '0;
        ram_data  = '0;
        step      = 1'b0;
        acc_addr  = '0;
        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        checks++;
        assert (ready === 1'b1 && state_out == matrix_pkg::IDLE && pc_out == '0) else begin
            errors++;
            $display("ERR %0t: after reset ready %b state %0d pc %0d",
                     $time, ready, state_out, pc_out);
        end
        check_accs("reset");
        immediate_products();
        shifted_products();
        ram_operand_products();
        idle_half_reload();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* list.f */
source/matrix_pkg.sv
source/operand_ram.sv
source/operand_double_buffer.sv
source/mac_cell.sv
source/systolic_grid.sv
source/instr_sequencer.sv
source/matrix_engine_top.sv
tests/tb_clock.sv
tests/matrix_engine_tb.sv

/* Bender.yml */
package:
  name: matrix_engine

sources:
  - files:
      - source/matrix_pkg.sv
      - source/operand_ram.sv
      - source/operand_double_buffer.sv
      - source/mac_cell.sv
      - source/systolic_grid.sv
      - source/instr_sequencer.sv
      - source/matrix_engine_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/matrix_engine_tb.sv
